/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_mpa_mips
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
FAIL_MSG   ?= CHECKS FAILED
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+testbench
rtl/mpa_pkg.sv
rtl/fetch_decode.sv
rtl/mips_reg_file.sv
rtl/load_unit.sv
rtl/mpa_mips_top.sv
testbench/tb_mpa_mips.sv

/* rtl/fetch_decode.sv */
module fetch_decode (
    input  logic                mem_debug_clk_gate,
    input  logic                HW_RSTn,
    input  mpa_pkg::debug_req_t dbg,
    output mpa_pkg::decode_t    dec,
    output mpa_pkg::word_t      im_rdata
);
    import mpa_pkg::*;

    imem_addr_t pc;                   // Program counter as word index
    imem_addr_t dbg_idx;              // Debug word index
    word_t      imem [IMEM_DEPTH];    // Instruction store
    word_t      instr;                // Fetched word
    logic       im_sel;               // Back-door targets this memory
    logic [5:0] opcode;

    assign im_sel  = dbg.active && (dbg.sel == DBG_IM);
    assign dbg_idx = dbg.addr[IMEM_AW-1:0];

    // PC steps once per retire edge and holds while halted
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= '0;
        end else if (!dbg.active) begin
            pc <= pc + imem_addr_t'(1);  // Wraps at IMEM_DEPTH
        end
    end

    // Debug write port
    always_ff @(posedge mem_debug_clk_gate) begin
        if (im_sel && dbg.we) begin
            imem[dbg_idx] <= dbg.wdata;
        end
    end

    // Asynchronous reads
    assign instr    = imem[pc];
    assign im_rdata = im_sel ? imem[dbg_idx] : '0;  // Zero when not selected

    // I-type field split
    assign opcode  = instr[31:26];
    assign dec.rs  = instr[25:21];
    assign dec.rt  = instr[20:16];
    assign dec.imm = instr[15:0];

    // Opcode to load kind
    always_comb begin
        case (opcode)
            OP_LBU:  dec.kind = LK_LBU;
            OP_LHU:  dec.kind = LK_LHU;
            OP_LW:   dec.kind = LK_LW;
            OP_LUI:  dec.kind = LK_LUI;
            default: dec.kind = LK_NONE;  // Everything else retires as a no-op
        endcase
    end

    // One retire per edge while running
    pc_step_a: assert property (
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        !dbg.active |=> pc == imem_addr_t'($past(pc) + imem_addr_t'(1))
    ) else $error("fetch_decode: pc 0x%0h, expected step from 0x%0h", pc, $past(pc));

endmodule

/* rtl/load_unit.sv */
module load_unit (
    input  logic                mem_debug_clk_gate,
    input  mpa_pkg::debug_req_t dbg,
    input  mpa_pkg::decode_t    dec,
    input  mpa_pkg::word_t      rs_data,
    output mpa_pkg::wb_t        wb,
    output mpa_pkg::word_t      dm_rdata
);
    import mpa_pkg::*;

    word_t      dmem [DMEM_DEPTH];  // Data store
    word_t      imm_sext;           // Sign-extended offset
    word_t      eff_addr;           // Base plus offset
    word_t      ld_word;            // Word at effective address
    dmem_addr_t ld_idx;
    dmem_addr_t dbg_idx;
    logic       dm_sel;

    assign dm_sel  = dbg.active && (dbg.sel == DBG_DM);
    assign dbg_idx = dbg.addr[DMEM_AW-1:0];

    // Effective address adder
    assign imm_sext = {{(DATA_W-16){dec.imm[15]}}, dec.imm};
    assign eff_addr = rs_data + imm_sext;
    assign ld_idx   = eff_addr[DMEM_AW-1:0];  // Word index wraps at depth

    // Debug write port
    always_ff @(posedge mem_debug_clk_gate) begin
        if (dm_sel && dbg.we) begin
            dmem[dbg_idx] <= dbg.wdata;
        end
    end

    // Asynchronous reads
    assign ld_word  = dmem[ld_idx];
    assign dm_rdata = dm_sel ? dmem[dbg_idx] : '0;

    // Write-back formatting
    always_comb begin
        case (dec.kind)
            LK_LUI: begin
                wb.wdata = {dec.imm, 16'h0000};  // Immediate to upper half
            end
            LK_LBU: begin
                wb.wdata = {24'h00_0000, ld_word[7:0]};
            end
            LK_LHU: begin
                wb.wdata = {16'h0000, ld_word[15:0]};
            end
            LK_LW: begin
                wb.wdata = ld_word;
            end
            default: begin
                wb.wdata = '0;
            end
        endcase
    end

    assign wb.waddr = dec.rt;                                  // I-type destination
    assign wb.we    = (dec.kind != LK_NONE) && !dbg.active;   // No retire while halted

    // Decoder output feeding this stage must stay known and legal
    kind_legal_a: assert property (
        @(posedge mem_debug_clk_gate)
        !$isunknown(dec.kind) && (dec.kind inside {LK_NONE, LK_LUI, LK_LBU, LK_LHU, LK_LW})
    ) else $error("load_unit: illegal dec.kind 0x%0h", dec.kind);

endmodule

/* rtl/mips_reg_file.sv */
module mips_reg_file (
    input  logic                mem_debug_clk_gate,
    input  logic                HW_RSTn,
    input  mpa_pkg::debug_req_t dbg,
    input  mpa_pkg::decode_t    dec,
    input  mpa_pkg::wb_t        wb,
    output mpa_pkg::word_t      rs_data,
    output mpa_pkg::word_t      mr_rdata
);
    import mpa_pkg::*;

    word_t     regs [2**REG_ADDR_W];  // General purpose registers
    reg_addr_t dbg_idx;
    logic      mr_sel;
    wb_t       wr;                    // Muxed write port

    assign mr_sel  = dbg.active && (dbg.sel == DBG_MR);
    assign dbg_idx = dbg.addr[REG_ADDR_W-1:0];

    // Debug owns the single write port while halted
    always_comb begin
        if (dbg.active) begin
            wr.we    = mr_sel && dbg.we;
            wr.waddr = dbg_idx;
            wr.wdata = dbg.wdata;
        end else begin
            wr = wb;  // Normal load write-back
        end
    end

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.waddr != '0)) begin  // $zero not writable
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // Combinational reads, $zero forced
    assign rs_data  = (dec.rs == '0) ? '0 : regs[dec.rs];
    assign mr_rdata = (mr_sel && (dbg_idx != '0)) ? regs[dbg_idx] : '0;

    // Load unit must drop write-back whenever the core is halted
    wb_quiet_a: assert property (
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        dbg.active |-> !wb.we
    ) else $error("mips_reg_file: wb.we high in debug, waddr 0x%0h", wb.waddr);

endmodule

/* rtl/mpa_mips_top.sv */
module mpa_mips_top (
    input  logic              mem_debug_clk_gate,
    input  logic              HW_RSTn,
    input  mpa_pkg::word_t    din,          // Debug write data
    output mpa_pkg::word_t    dout,         // Debug read data
    input  mpa_pkg::word_t    addr,         // Debug word index
    input  mpa_pkg::dbg_sel_t debug_func,   // 1 IM, 2 DM, 3 MR
    input  logic              debug_we,
    input  logic              mem_debug     // Halt and open back door
);
    import mpa_pkg::*;

    debug_req_t dbg;       // Bundled debug pins
    decode_t    dec;       // Fetch to regfile and load stage
    wb_t        wb;        // Load stage back to regfile
    word_t      rs_data;   // Base register value
    word_t      im_rdata;
    word_t      dm_rdata;
    word_t      mr_rdata;

    // Pack back-door pins
    assign dbg = '{
        active: mem_debug,
        sel:    debug_func,
        we:     debug_we,
        addr:   addr,
        wdata:  din
    };

    // Producer, PC and instruction memory
    fetch_decode u_fetch_decode (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .dbg                (dbg),
        .dec                (dec),
        .im_rdata           (im_rdata)
    );

    // Register file between the stages
    mips_reg_file u_mips_reg_file (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .dbg                (dbg),
        .dec                (dec),
        .wb                 (wb),
        .rs_data            (rs_data),
        .mr_rdata           (mr_rdata)
    );

    // Consumer, data memory and write-back
    load_unit u_load_unit (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .dbg                (dbg),
        .dec                (dec),
        .rs_data            (rs_data),
        .wb                 (wb),
        .dm_rdata           (dm_rdata)
    );

    // At most one stage drives a nonzero word, so OR is the read mux
    assign dout = im_rdata | dm_rdata | mr_rdata;

endmodule

/* rtl/mpa_pkg.sv */
package mpa_pkg;

    // Datapath widths
    localparam int DATA_W     = 32;  // Data and instruction word
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    // Memory depths in words
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_LBU = 6'b10_0100;  // Load byte unsigned
    localparam logic [5:0] OP_LHU = 6'b10_0101;  // Load halfword unsigned
    localparam logic [5:0] OP_LW  = 6'b10_0011;  // Load word
    localparam logic [5:0] OP_LUI = 6'b00_1111;  // Load upper immediate

    // Plain vector types
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [IMEM_AW-1:0]    imem_addr_t;
    typedef logic [DMEM_AW-1:0]    dmem_addr_t;
    typedef logic [1:0]            dbg_sel_t;

    // Back-door select codes on debug_func, 0 selects nothing
    localparam dbg_sel_t DBG_IM = 2'd1;  // Instruction memory
    localparam dbg_sel_t DBG_DM = 2'd2;  // Data memory
    localparam dbg_sel_t DBG_MR = 2'd3;  // Register file

    // Load kind from the decoder
    typedef enum logic [2:0] {
        LK_NONE,  // Unsupported opcode, no write-back
        LK_LUI,
        LK_LBU,
        LK_LHU,
        LK_LW
    } load_kind_e;

    // Debug pins bundled at the top
    typedef struct packed {
        logic     active;  // mem_debug, core halted
        dbg_sel_t sel;     // Target store
        logic     we;      // Write strobe, level
        word_t    addr;    // Word index, low bits used
        word_t    wdata;
    } debug_req_t;

    // Decoded I-type fields
    typedef struct packed {
        load_kind_e  kind;
        reg_addr_t   rs;   // Base register
        reg_addr_t   rt;   // Destination
        logic [15:0] imm;
    } decode_t;

    // Write-back request into the register file
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

endpackage

/* testbench/tb_mips_model.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// Shadow copies of the three stores
word_t m_imem [IMEM_DEPTH];
word_t m_dmem [DMEM_DEPTH];
word_t m_regs [2**REG_ADDR_W];  // Entry 0 stays zero

// I-type word from its fields
function automatic word_t enc_itype(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// One of the four loads, all fields random
function automatic word_t rand_load();
    logic [5:0] op;
    case ($urandom_range(3, 0))
        0:       op = OP_LBU;
        1:       op = OP_LHU;
        2:       op = OP_LW;
        default: op = OP_LUI;
    endcase
    return enc_itype(op, reg_addr_t'($urandom()), reg_addr_t'($urandom()), 16'($urandom()));
endfunction

// Any opcode outside the load set
function automatic word_t rand_bad_op();
    logic [5:0] op;
    op = 6'($urandom());
    while (op inside {OP_LBU, OP_LHU, OP_LW, OP_LUI}) begin
        op = 6'($urandom());  // Redraw until unsupported
    end
    return enc_itype(op, reg_addr_t'($urandom()), reg_addr_t'($urandom()), 16'($urandom()));
endfunction

// Retire one instruction against the shadow state
function automatic void model_exec(input word_t instr);
    reg_addr_t rt;
    word_t     ea;
    word_t     mem;
    word_t     res;
    logic      wr;
    rt  = instr[20:16];
    ea  = m_regs[instr[25:21]] + {{16{instr[15]}}, instr[15:0]};  // Base plus signed offset
    mem = m_dmem[ea[DMEM_AW-1:0]];  // Word index wraps at depth
    wr  = 1'b1;
    case (instr[31:26])
        OP_LBU:  res = {24'h00_0000, mem[7:0]};
        OP_LHU:  res = {16'h0000, mem[15:0]};
        OP_LW:   res = mem;
        OP_LUI:  res = {instr[15:0], 16'h0000};
        default: begin
            res = '0;
            wr  = 1'b0;  // No-op retire
        end
    endcase
    if (wr && (rt != '0)) begin
        m_regs[rt] = res;
    end
endfunction

// Straight run from PC 0
function automatic void model_run(input int n);
    for (int k = 0; k < n; k++) begin
        model_exec(m_imem[k % IMEM_DEPTH]);
    end
endfunction

function automatic void model_clear_regs();
    for (int r = 0; r < 2**REG_ADDR_W; r++) begin
        m_regs[r] = '0;
    end
endfunction

// Back-door write as the model sees it
function automatic void model_poke(input dbg_sel_t sel, input word_t a, input word_t d);
    case (sel)
        DBG_IM:  m_imem[a[IMEM_AW-1:0]] = d;
        DBG_DM:  m_dmem[a[DMEM_AW-1:0]] = d;
        DBG_MR:  begin
            if (a[REG_ADDR_W-1:0] != '0) begin
                m_regs[a[REG_ADDR_W-1:0]] = d;
            end
        end
        default: ;  // Select 0 touches nothing
    endcase
endfunction

// Expected dout for a back-door read
function automatic word_t model_peek(input dbg_sel_t sel, input word_t a);
    case (sel)
        DBG_IM:  return m_imem[a[IMEM_AW-1:0]];
        DBG_DM:  return m_dmem[a[DMEM_AW-1:0]];
        DBG_MR:  return m_regs[a[REG_ADDR_W-1:0]];
        default: return '0;
    endcase
endfunction

`endif

/* testbench/tb_mpa_mips.sv */
module tb_mpa_mips;
    import mpa_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int DRIVE_DLY        = 2;   // Input skew after the rising edge
    localparam int RST_CYCLES       = 10;
    localparam int N_DBG            = 16;  // Round trips per store
    localparam int DBG_TEST_CYCLES  = 6 * N_DBG + 8;
    localparam int PROG_TEST_CYCLES = 600;  // Load, run, pauses, readback
    localparam int TOTAL_CYCLES     = RST_CYCLES + DBG_TEST_CYCLES + 4 * PROG_TEST_CYCLES;

    logic     mem_debug_clk_gate;
    logic     HW_RSTn;
    word_t    din;
    word_t    dout;
    word_t    addr;
    dbg_sel_t debug_func;
    logic     debug_we;
    logic     mem_debug;

    int test_checks;
    int test_errs;
    int total_checks;
    int total_errs;

    `include "tb_mips_model.svh"

    mpa_mips_top uut (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .din                (din),
        .dout               (dout),
        .addr               (addr),
        .debug_func         (debug_func),
        .debug_we           (debug_we),
        .mem_debug          (mem_debug)
    );

    initial begin
        mem_debug_clk_gate = 1'b0;
        forever #(CLK_PERIOD / 2) mem_debug_clk_gate = ~mem_debug_clk_gate;
    end

    // Hard stop well past the worst-case test length
    initial begin : watchdog
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("watchdog: run did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic tick();
        @(posedge mem_debug_clk_gate);
        #(DRIVE_DLY);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        test_checks++;
        assert (got === exp)
        else begin
            test_errs++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic dbg_write(input dbg_sel_t sel, input word_t a, input word_t d);
        mem_debug  = 1'b1;
        debug_func = sel;
        addr       = a;
        din        = d;
        debug_we   = 1'b1;
        tick();  // Lands at this edge
        debug_we   = 1'b0;
        model_poke(sel, a, d);
    endtask

    task automatic dbg_read(input dbg_sel_t sel, input word_t a, output word_t v);
        mem_debug  = 1'b1;
        debug_func = sel;
        addr       = a;
        debug_we   = 1'b0;
        #(CLK_PERIOD - 2 * DRIVE_DLY);  // Just ahead of the next edge
        v = dout;
        tick();
    endtask

    // Write a random word, read it back
    task automatic roundtrip(input dbg_sel_t sel, input word_t a);
        word_t v;
        dbg_write(sel, a, $urandom());
        dbg_read(sel, a, v);
        check_word($sformatf("dout sel %0d addr 0x%0h", sel, a), v, model_peek(sel, a));
    endtask

    // Exactly one retire edge
    task automatic step_once();
        mem_debug = 1'b0;
        debug_we  = 1'b0;
        tick();
        mem_debug = 1'b1;  // Halted again before the next edge
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step_once();
    endtask

    // Random program and data, pushed through the back door
    task automatic new_program(input int bad_pct);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            m_imem[i] = (int'($urandom_range(99, 0)) < bad_pct) ? rand_bad_op() : rand_load();
            dbg_write(DBG_IM, word_t'(i), m_imem[i]);
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dbg_write(DBG_DM, word_t'(i), $urandom());
        end
    endtask

    task automatic check_regs();
        word_t v;
        for (int r = 0; r < 2**REG_ADDR_W; r++) begin
            dbg_read(DBG_MR, word_t'(r), v);
            check_word($sformatf("dout r%0d", r), v, m_regs[r]);
        end
    endtask

    task automatic check_dmem();
        word_t v;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dbg_read(DBG_DM, word_t'(i), v);
            check_word($sformatf("dout dmem[%0d]", i), v, m_dmem[i]);
        end
    endtask

    // Random back-door read while halted mid-program
    task automatic pause_read();
        dbg_sel_t sel;
        word_t    a;
        word_t    v;
        sel = ($urandom_range(1, 0) == 0) ? DBG_DM : DBG_MR;
        a   = word_t'($urandom_range(63, 0));
        dbg_read(sel, a, v);
        check_word($sformatf("dout pause sel %0d addr 0x%0h", sel, a), v, model_peek(sel, a));
    endtask

    task automatic pulse_reset();
        HW_RSTn   = 1'b0;  // Async clear of PC and registers
        mem_debug = 1'b1;
        repeat (3) tick();
        HW_RSTn   = 1'b1;
    endtask

    task automatic end_test(input string name);
        $display("test %-16s %s  checks %0d  errors %0d", name,
                 (test_errs == 0) ? "pass" : "fail", test_checks, test_errs);
        total_checks += test_checks;
        total_errs   += test_errs;
        test_checks   = 0;
        test_errs     = 0;
    endtask

    initial begin : stimulus
        int n_pre;
        void'($urandom(4393));
        HW_RSTn      = 1'b0;
        mem_debug    = 1'b1;  // Halted from the start
        debug_func   = '0;
        debug_we     = 1'b0;
        addr         = '0;
        din          = '0;
        test_checks  = 0;
        test_errs    = 0;
        total_checks = 0;
        total_errs   = 0;
        model_clear_regs();
        repeat (RST_CYCLES) @(posedge mem_debug_clk_gate);
        #(DRIVE_DLY);
        HW_RSTn = 1'b1;

        for (int i = 0; i < N_DBG; i++) begin
            roundtrip(DBG_IM, word_t'($urandom_range(IMEM_DEPTH - 1, 0)));
            roundtrip(DBG_DM, word_t'($urandom_range(DMEM_DEPTH - 1, 0)));
            roundtrip(DBG_MR, word_t'($urandom_range(31, 1)));
        end
        roundtrip(DBG_MR, '0);                          // $zero keeps reading zero
        roundtrip(dbg_sel_t'(0), word_t'($urandom()));  // No store selected
        end_test("debug_access");

        new_program(0);
        model_run(IMEM_DEPTH);
        run_cycles(IMEM_DEPTH);  // PC wraps back to 0
        check_regs();
        end_test("load_program");

        new_program(50);  // Half the slots unsupported
        model_run(IMEM_DEPTH);
        run_cycles(IMEM_DEPTH);
        check_regs();
        check_dmem();
        end_test("unsupported_ops");

        new_program(0);
        for (int k = 0; k < IMEM_DEPTH; k++) begin
            step_once();
            model_exec(m_imem[k]);
            if ($urandom_range(3, 0) == 0) begin
                repeat ($urandom_range(3, 1)) pause_read();
            end
        end
        check_regs();
        end_test("halt_pauses");

        new_program(0);
        n_pre = int'($urandom_range(60, 5));
        run_cycles(n_pre);
        pulse_reset();
        model_clear_regs();  // Fresh start, memories untouched
        model_run(IMEM_DEPTH);
        run_cycles(IMEM_DEPTH);
        check_regs();
        end_test("reset_restart");

        $display("summary: 5 tests, %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
